// File: Bender.yml
package:
  name: rv_front_end

sources:
  - verilog/rvDecodePkg.sv
  - verilog/fetchUnit.sv
  - verilog/instQueue.sv
  - verilog/branchTagTracker.sv
  - verilog/instDecoder.sv
  - verilog/rvFrontEnd.sv
  - target: test
    files:
      - test/rvFrontEndTb.sv

// File: test/rvFrontEndTb.sv
/*
 * testbench for the instruction front end
 * table of decode rows, then a branch stall with queue fill and tag free
 */
`timescale 1ns/100ps
`default_nettype none

module rvFrontEndTb
    import rvDecodePkg::*;
();

    typedef enum logic [2:0] {immI, immU, immJ, immS, immB, immNone} immKindT;

    typedef struct packed {
        logic [xlen-1:0] word;
        opCodeT          op;
        opClassT         cls;
        immKindT         kind;
        logic [xlen-1:0] imm;
    } rowT;

    logic                    clk;
    logic                    rst;
    logic                    fetchValid;
    logic [xlen-1:0]         fetchInst;
    logic                    bFreeEn;
    logic [branchTagW-1:0]   bFreeNum;
    logic                    queueFull;
    logic                    decValid;
    decodedInstT             decOut;
    logic [branchRsSize-1:0] busyMask;
    logic                    branchFree;

    rowT                     rows[$];
    string                   rowNames[$];
    decodedInstT             recs[$];
    logic [branchRsSize-1:0] masks[$];

    integer                  seed = 32'ha3f9_3ba7;
    logic [xlen-1:0]         pcModel = '0;
    logic [branchRsSize-1:0] maskModel = '0;
    logic [branchTagW-1:0]   tailModel = '0;
    int                      errors = 0;
    int                      testErrs = 0;
    int                      testsRun = 0;
    int                      testsFailed = 0;
    int                      cycles = 0;
    int                      limit = 0;
    // reset, pushes, stall window, free and drain of the stall sequence
    int                      seqCycles = 40;

    rvFrontEnd dut (
        .clk        (clk),
        .rst        (rst),
        .fetchValid (fetchValid),
        .fetchInst  (fetchInst),
        .bFreeEn    (bFreeEn),
        .bFreeNum   (bFreeNum),
        .queueFull  (queueFull),
        .decValid   (decValid),
        .decOut     (decOut),
        .busyMask   (busyMask),
        .branchFree (branchFree)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // capture every record in the middle of its valid cycle
    always @(negedge clk) begin
        if (!rst && decValid) begin
            recs.push_back(decOut);
            masks.push_back(busyMask);
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (limit > 0 && cycles > limit) begin
            $display("timeout after %0d cycles, the front end stopped producing records", cycles);
            $display("Simulation failed");
            $finish;
        end
    end

    function automatic logic [4:0] rand5();
        rand5 = $random(seed);
    endfunction

    // encoders place the fields by the RISC-V layouts, register slots are random
    function automatic logic [31:0] encR(input logic [6:0] f7, input logic [2:0] f3,
                                         input logic [6:0] opc);
        encR = {f7, rand5(), rand5(), f3, rand5(), opc};
    endfunction

    function automatic logic [31:0] encI(input logic [11:0] v, input logic [2:0] f3,
                                         input logic [6:0] opc);
        encI = {v, rand5(), f3, rand5(), opc};
    endfunction

    function automatic logic [31:0] encS(input logic [11:0] v, input logic [2:0] f3);
        encS = {v[11:5], rand5(), rand5(), f3, v[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] encB(input logic [12:0] v, input logic [2:0] f3);
        encB = {v[12], v[10:5], rand5(), rand5(), f3, v[4:1], v[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] encU(input logic [19:0] v, input logic [6:0] opc);
        encU = {v, rand5(), opc};
    endfunction

    function automatic logic [31:0] encJ(input logic [20:0] v);
        encJ = {v[20], v[10:1], v[11], v[19:12], rand5(), 7'b1101111};
    endfunction

    task automatic addRow(input string n, input logic [31:0] w, input opCodeT op,
                          input opClassT cls, input immKindT kind, input logic [31:0] imm);
        rowT r;
        r.word = w;
        r.op   = op;
        r.cls  = cls;
        r.kind = kind;
        r.imm  = imm;
        rows.push_back(r);
        rowNames.push_back(n);
    endtask

    task automatic rowR(input string n, input logic [6:0] f7, input logic [2:0] f3,
                        input logic [6:0] opc, input opCodeT op, input opClassT cls);
        addRow(n, encR(f7, f3, opc), op, cls, immNone, 32'h0);
    endtask

    task automatic rowI(input string n, input logic [11:0] v, input logic [2:0] f3,
                        input logic [6:0] opc, input opCodeT op, input opClassT cls);
        addRow(n, encI(v, f3, opc), op, cls, immI, {{20{v[11]}}, v});
    endtask

    task automatic rowS(input string n, input logic [11:0] v, input logic [2:0] f3,
                        input opCodeT op);
        addRow(n, encS(v, f3), op, classStore, immS, {{20{v[11]}}, v});
    endtask

    task automatic rowB(input string n, input logic [12:0] v, input logic [2:0] f3,
                        input opCodeT op);
        addRow(n, encB(v, f3), op, classBranch, immB, {{19{v[12]}}, v});
    endtask

    task automatic buildTable();
        addRow("lui", encU(20'hA5A5A, 7'b0110111), opLui, classLui, immU, 32'hA5A5A000);
        addRow("auipc", encU(20'h5A5A5, 7'b0010111), opAuipc, classAuipc, immU, 32'h5A5A5000);
        addRow("jalPos", encJ(21'h0AAAAA), opJal, classJal, immJ, 32'h000AAAAA);
        addRow("jalNeg", encJ(21'h155554), opJal, classJal, immJ, 32'hFFF55554);
        rowI("jalr", 12'h800, 3'b000, 7'b1100111, opJalr, classJalr);
        rowB("beq", 13'h1FFE, f3Beq, opBeq);
        rowB("bne", 13'h0AAA, f3Bne, opBne);
        rowB("blt", 13'h1554, f3Blt, opBlt);
        rowB("bge", 13'h0FFE, f3Bge, opBge);
        rowB("bltu", 13'h1000, f3Bltu, opBltu);
        rowB("bgeu", 13'h0002, f3Bgeu, opBgeu);
        rowI("lb", 12'hFFF, f3Lb, 7'b0000011, opLb, classLoad);
        rowI("lh", 12'h7FF, f3Lh, 7'b0000011, opLh, classLoad);
        rowI("lw", 12'h800, f3Lw, 7'b0000011, opLw, classLoad);
        rowI("lbu", 12'h123, f3Lbu, 7'b0000011, opLbu, classLoad);
        rowI("lhu", 12'hEDC, f3Lhu, 7'b0000011, opLhu, classLoad);
        rowS("sb", 12'hFFF, f3Sb, opSb);
        rowS("sh", 12'h7FF, f3Sh, opSh);
        rowS("sw", 12'hA5A, f3Sw, opSw);
        rowI("addi", 12'hF00, f3AddSub, 7'b0010011, opAdd, classRegImm);
        rowI("slti", 12'h0FF, f3Slt, 7'b0010011, opSlt, classRegImm);
        rowI("sltiu", 12'h801, f3Sltu, 7'b0010011, opSltu, classRegImm);
        rowI("xori", 12'h555, f3Xor, 7'b0010011, opXor, classRegImm);
        rowI("ori", 12'hAAA, f3Or, 7'b0010011, opOr, classRegImm);
        rowI("andi", 12'h7F0, f3And, 7'b0010011, opAnd, classRegImm);
        rowI("slli", {7'h00, 5'd7}, f3Sll, 7'b0010011, opSll, classRegImm);
        rowI("srli", {7'h00, 5'd13}, f3SrlSra, 7'b0010011, opSrl, classRegImm);
        rowI("srai", {7'h20, 5'd31}, f3SrlSra, 7'b0010011, opSra, classRegImm);
        rowR("add", 7'h00, f3AddSub, 7'b0110011, opAdd, classRegReg);
        rowR("sub", 7'h20, f3AddSub, 7'b0110011, opSub, classRegReg);
        rowR("sll", 7'h00, f3Sll, 7'b0110011, opSll, classRegReg);
        rowR("slt", 7'h00, f3Slt, 7'b0110011, opSlt, classRegReg);
        rowR("sltu", 7'h00, f3Sltu, 7'b0110011, opSltu, classRegReg);
        rowR("xor", 7'h00, f3Xor, 7'b0110011, opXor, classRegReg);
        rowR("srl", 7'h00, f3SrlSra, 7'b0110011, opSrl, classRegReg);
        rowR("sra", 7'h20, f3SrlSra, 7'b0110011, opSra, classRegReg);
        rowR("or", 7'h00, f3Or, 7'b0110011, opOr, classRegReg);
        rowR("and", 7'h00, f3And, 7'b0110011, opAnd, classRegReg);
        // words that must fall back to a nop
        rowR("badOpcode", 7'h00, 3'b000, 7'b1111111, opNop, classNop);
        rowI("fence", 12'h0FF, 3'b000, 7'b0001111, opNop, classNop);
        rowR("addBadF7", 7'h01, f3AddSub, 7'b0110011, opNop, classNop);
        rowR("xorAltF7", 7'h20, f3Xor, 7'b0110011, opNop, classNop);
        rowR("srlBadF7", 7'h40, f3SrlSra, 7'b0110011, opNop, classNop);
        rowI("slliBadF7", {7'h20, 5'd3}, f3Sll, 7'b0010011, opNop, classNop);
    endtask

    task automatic checkVal(input string test, input string what,
                            input logic [31:0] expV, input logic [31:0] actV);
        assert (actV === expV) else begin
            $display("CHECK FAILED %s %s expected %h actual %h", test, what, expV, actV);
            errors++;
            testErrs++;
        end
    endtask

    task automatic finishTest(input string name);
        testsRun++;
        if (testErrs == 0) begin
            $display("PASS %s", name);
        end else begin
            $display("FAIL %s with %0d bad checks", name, testErrs);
            testsFailed++;
        end
        testErrs = 0;
    endtask

    task automatic applyReset();
        @(posedge clk);
        rst        <= 1'b1;
        fetchValid <= 1'b0;
        bFreeEn    <= 1'b0;
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        pcModel   = '0;
        maskModel = '0;
        tailModel = '0;
        recs.delete();
        masks.delete();
    endtask

    task automatic pushWord(input logic [31:0] w);
        @(posedge clk);
        fetchValid <= 1'b1;
        fetchInst  <= w;
        pcModel = pcModel + 32'd4;
        @(posedge clk);
        fetchValid <= 1'b0;
    endtask

    task automatic waitRecords(input int n);
        while (recs.size() < n) begin
            @(posedge clk);
        end
    endtask

    task automatic freeTag(input logic [branchTagW-1:0] tag);
        @(posedge clk);
        bFreeEn  <= 1'b1;
        bFreeNum <= tag;
        @(posedge clk);
        bFreeEn <= 1'b0;
        maskModel[tag] = 1'b0;
    endtask

    task automatic runTable();
        rowT             r;
        decodedInstT     rec;
        logic [xlen-1:0] expAddr;
        logic [xlen-1:0] actImm;
        string           n;
        for (int i = 0; i < rows.size(); i++) begin
            r = rows[i];
            n = rowNames[i];
            recs.delete();
            masks.delete();
            expAddr = pcModel;
            pushWord(r.word);
            waitRecords(1);
            rec = recs[0];
            checkVal(n, "opCode", r.op, rec.opCode);
            checkVal(n, "opClass", r.cls, rec.opClass);
            checkVal(n, "regNameO", r.word[19:15], rec.regNameO);
            checkVal(n, "regNameT", r.word[24:20], rec.regNameT);
            checkVal(n, "rdName", r.word[11:7], rec.rdName);
            checkVal(n, "instAddr", expAddr, rec.instAddr);
            case (r.kind)
                immI:    actImm = rec.imm;
                immU:    actImm = rec.uImm;
                immJ:    actImm = rec.jImm;
                immS:    actImm = rec.sImm;
                immB:    actImm = rec.bImm;
                default: actImm = r.imm;
            endcase
            if (r.kind != immNone) begin
                checkVal(n, "immediate", r.imm, actImm);
            end
            // every branch takes the next tag and gives it straight back
            if (r.word[6:0] == 7'b1100011) begin
                maskModel[tailModel] = 1'b1;
                checkVal(n, "branchTag", tailModel, rec.branchTag);
                checkVal(n, "busyMask", maskModel, masks[0]);
                freeTag(tailModel);
                tailModel = tailModel + 1'b1;
            end
            finishTest(n);
        end
    endtask

    task automatic runStallSeq();
        logic [31:0]     words [8];
        logic [xlen-1:0] expAddr [8];
        applyReset();
        // five branches, then three addi words that queue up behind the fifth
        for (int i = 0; i < 8; i++) begin
            words[i] = (i < 5) ? encB(13'h0010, f3Beq) : encI(12'h004, f3AddSub, 7'b0010011);
        end
        for (int i = 0; i < 8; i++) begin
            @(posedge clk);
            fetchValid <= 1'b1;
            fetchInst  <= words[i];
            expAddr[i] = pcModel;
            pcModel = pcModel + 32'd4;
        end
        @(posedge clk);
        fetchValid <= 1'b0;
        waitRecords(4);
        // the fifth branch has to sit at the head while no tag is free
        repeat (3) @(posedge clk);
        @(negedge clk);
        checkVal("tagAllocate", "record count", 4, recs.size());
        for (int i = 0; i < 4; i++) begin
            maskModel[tailModel] = 1'b1;
            checkVal("tagAllocate", "branchTag", tailModel, recs[i].branchTag);
            checkVal("tagAllocate", "instAddr", expAddr[i], recs[i].instAddr);
            checkVal("tagAllocate", "opCode", opBeq, recs[i].opCode);
            tailModel = tailModel + 1'b1;
        end
        checkVal("tagAllocate", "busyMask", maskModel, busyMask);
        checkVal("tagAllocate", "branchFree", 0, branchFree);
        checkVal("tagAllocate", "decValid", 0, decValid);
        checkVal("tagAllocate", "stall opCode", opNop, decOut.opCode);
        finishTest("tagAllocate");
        checkVal("queueOrder", "queueFull", 1, queueFull);
        freeTag(2'd1);
        waitRecords(8);
        maskModel[tailModel] = 1'b1;
        checkVal("queueOrder", "branchTag", tailModel, recs[4].branchTag);
        checkVal("queueOrder", "busyMask", maskModel, masks[4]);
        checkVal("queueOrder", "opCode", opBeq, recs[4].opCode);
        for (int i = 4; i < 8; i++) begin
            checkVal("queueOrder", "instAddr", expAddr[i], recs[i].instAddr);
        end
        for (int i = 5; i < 8; i++) begin
            checkVal("queueOrder", "opCode", opAdd, recs[i].opCode);
            checkVal("queueOrder", "rdName", words[i][11:7], recs[i].rdName);
        end
        @(negedge clk);
        checkVal("queueOrder", "queueFull", 0, queueFull);
        finishTest("queueOrder");
    endtask

    initial begin
        rst        = 1'b1;
        fetchValid = 1'b0;
        fetchInst  = '0;
        bFreeEn    = 1'b0;
        bFreeNum   = '0;
        buildTable();
        limit = rows.size() * 4 + seqCycles + 100;
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        runTable();
        runStallSeq();
        $display("%0d tests, %0d passed, %0d failed, %0d checks failed",
                 testsRun, testsRun - testsFailed, testsFailed, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog.f
verilog/rvDecodePkg.sv
verilog/fetchUnit.sv
verilog/instQueue.sv
verilog/branchTagTracker.sv
verilog/instDecoder.sv
verilog/rvFrontEnd.sv
test/rvFrontEndTb.sv

// File: verilog/branchTagTracker.sv
/*
 * branch tag tracker with busy mask, allocation tail and in-flight count
 */
`timescale 1ns/100ps
`default_nettype none

module branchTagTracker
    import rvDecodePkg::*;
(
    input  wire logic                  clk,
    input  wire logic                  rst,
    input  wire logic                  allocate,
    input  wire logic                  bFreeEn,
    input  wire logic [branchTagW-1:0] bFreeNum,
    output logic [branchTagW-1:0]      allocTag,
    output logic [branchRsSize-1:0]    busyMask,
    output logic                       branchFree
);

    logic [branchTagW-1:0] tail;
    logic [branchTagW:0]   count;

    // new branches always take the tail slot
    assign allocTag = tail;
    assign branchFree = (count < (branchTagW + 1)'(branchRsSize));

    always_ff @(posedge clk) begin
        if (rst) begin
            busyMask <= '0;
            tail     <= '0;
            count    <= '0;
        end else begin
            if (bFreeEn) begin
                busyMask[bFreeNum] <= 1'b0;
            end
            // set after clear so a same-slot alloc wins
            if (allocate) begin
                busyMask[tail] <= 1'b1;
                if (tail == branchTagW'(branchRsSize - 1)) begin
                    tail <= '0;
                end else begin
                    tail <= tail + 1'b1;
                end
            end
            case ({allocate, bFreeEn})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // decoder must stall branches once every slot is taken
    allocWhenBusy: assert property (
        @(posedge clk) disable iff (rst)
        allocate |-> branchFree
    ) else $error("branch tag allocated with no free slot");

    // branch unit may only release a slot it holds
    freeIdleSlot: assert property (
        @(posedge clk) disable iff (rst)
        bFreeEn |-> busyMask[bFreeNum]
    ) else $error("free of branch slot %0d which is not busy", bFreeNum);

endmodule

`default_nettype wire

// File: verilog/fetchUnit.sv
/*
 * fetch unit with the program counter and queue entry formation
 */
`timescale 1ns/100ps
`default_nettype none

module fetchUnit
    import rvDecodePkg::*;
(
    input  wire logic            clk,
    input  wire logic            rst,
    input  wire logic            fetchValid,
    input  wire logic [xlen-1:0] fetchInst,
    input  wire logic            queueFull,
    output logic                 push,
    output fetchEntryT           pushEntry
);

    logic [xlen-1:0] pc;

    // every strobed word is accepted, the source watches queueFull
    assign push = fetchValid;

    assign pushEntry.pc       = pc;
    assign pushEntry.inst.raw = fetchInst;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= '0;
        end else if (push) begin
            pc <= pc + xlen'(4);
        end
    end

    // the queue has no room to take the word, it would be lost
    pushWhileFull: assert property (
        @(posedge clk) disable iff (rst)
        !(push && queueFull)
    ) else $error("fetch strobe while instruction queue is full");

endmodule

`default_nettype wire

// File: verilog/instDecoder.sv
/*
 * instruction decoder with queue pop, branch stall and tag allocation
 * class and opcode decode, immediate forms, registered decoded record
 */
`timescale 1ns/100ps
`default_nettype none

module instDecoder
    import rvDecodePkg::*;
(
    input  wire logic                  clk,
    input  wire logic                  rst,
    input  wire fetchEntryT            head,
    input  wire logic                  empty,
    input  wire logic                  branchFree,
    input  wire logic [branchTagW-1:0] allocTag,
    output logic                       pop,
    output logic                       allocate,
    output logic                       decValid,
    output decodedInstT                decOut
);

    instWordT   word;
    logic [2:0] f3;
    logic [6:0] f7;
    logic       isBranch;
    opCodeT     nextOp;
    opClassT    nextClass;

    // integer op decode, shared by both arithmetic classes
    function automatic opCodeT aluOp(
        input logic [2:0] fn3,
        input logic [6:0] fn7,
        input logic       regReg
    );
        opCodeT res;
        logic   baseOk;
        res = opNop;
        // immediate forms carry immediate bits in funct7 except for shifts
        baseOk = !regReg || (fn7 == funct7Base);
        case (fn3)
            f3AddSub: begin
                if (!regReg || fn7 == funct7Base) begin
                    res = opAdd;
                end else if (fn7 == funct7Alt) begin
                    res = opSub;
                end
            end
            f3Sll: begin
                if (fn7 == funct7Base) begin
                    res = opSll;
                end
            end
            f3Slt:  res = baseOk ? opSlt : opNop;
            f3Sltu: res = baseOk ? opSltu : opNop;
            f3Xor:  res = baseOk ? opXor : opNop;
            f3SrlSra: begin
                if (fn7 == funct7Base) begin
                    res = opSrl;
                end else if (fn7 == funct7Alt) begin
                    res = opSra;
                end
            end
            f3Or:   res = baseOk ? opOr : opNop;
            f3And:  res = baseOk ? opAnd : opNop;
            default: res = opNop;
        endcase
        return res;
    endfunction

    assign word     = head.inst;
    assign f3       = word.r.funct3;
    assign f7       = word.r.funct7;
    assign isBranch = (word.r.opcode == classBranch);

    // a branch waits at the head until a tag is free
    assign pop      = !empty && !(isBranch && !branchFree);
    assign allocate = pop && isBranch;

    always_comb begin
        nextOp = opNop;
        case (word.r.opcode)
            classLui:   nextOp = opLui;
            classAuipc: nextOp = opAuipc;
            classJal:   nextOp = opJal;
            classJalr:  nextOp = opJalr;
            classBranch: begin
                case (f3)
                    f3Beq:   nextOp = opBeq;
                    f3Bne:   nextOp = opBne;
                    f3Blt:   nextOp = opBlt;
                    f3Bge:   nextOp = opBge;
                    f3Bltu:  nextOp = opBltu;
                    f3Bgeu:  nextOp = opBgeu;
                    default: nextOp = opNop;
                endcase
            end
            classLoad: begin
                case (f3)
                    f3Lb:    nextOp = opLb;
                    f3Lh:    nextOp = opLh;
                    f3Lw:    nextOp = opLw;
                    f3Lbu:   nextOp = opLbu;
                    f3Lhu:   nextOp = opLhu;
                    default: nextOp = opNop;
                endcase
            end
            classStore: begin
                case (f3)
                    f3Sb:    nextOp = opSb;
                    f3Sh:    nextOp = opSh;
                    f3Sw:    nextOp = opSw;
                    default: nextOp = opNop;
                endcase
            end
            classRegImm: nextOp = aluOp(f3, f7, 1'b0);
            classRegReg: nextOp = aluOp(f3, f7, 1'b1);
            default:     nextOp = opNop;
        endcase
        // anything not understood leaves as a plain nop
        nextClass = (nextOp == opNop) ? classNop : opClassT'(word.r.opcode);
    end

    always_ff @(posedge clk) begin
        // payload, only meaningful while decValid is high
        if (pop) begin
            decOut.instAddr  <= head.pc;
            decOut.imm       <= {{(xlen - 12){word.i.imm11_0[11]}}, word.i.imm11_0};
            decOut.uImm      <= {word.u.imm31_12, {(xlen - 20){1'b0}}};
            decOut.jImm      <= {{(xlen - 21){word.j.imm20}}, word.j.imm20,
                                 word.j.imm19_12, word.j.imm11, word.j.imm10_1, 1'b0};
            decOut.sImm      <= {{(xlen - 12){word.s.imm11_5[6]}}, word.s.imm11_5,
                                 word.s.imm4_0};
            decOut.bImm      <= {{(xlen - 13){word.b.imm12}}, word.b.imm12, word.b.imm11,
                                 word.b.imm10_5, word.b.imm4_1, 1'b0};
            decOut.branchTag <= allocTag;
        end
        if (rst) begin
            decValid        <= 1'b0;
            decOut.regNameO <= nameFree;
            decOut.regNameT <= nameFree;
            decOut.rdName   <= nameFree;
            decOut.opCode   <= opNop;
            decOut.opClass  <= classNop;
        end else begin
            decValid <= pop;
            if (pop) begin
                // names always taken from the R-type slots
                decOut.regNameO <= word.r.rs1;
                decOut.regNameT <= word.r.rs2;
                decOut.rdName   <= word.r.rd;
                decOut.opCode   <= nextOp;
                decOut.opClass  <= nextClass;
            end else begin
                decOut.opCode  <= opNop;
                decOut.opClass <= classNop;
            end
        end
    end

endmodule

`default_nettype wire

// File: verilog/instQueue.sv
/*
 * four entry circular instruction queue
 * head view with pop, full and empty levels
 */
`timescale 1ns/100ps
`default_nettype none

module instQueue
    import rvDecodePkg::*;
(
    input  wire logic       clk,
    input  wire logic       rst,
    input  wire logic       push,
    input  wire fetchEntryT pushEntry,
    input  wire logic       pop,
    output fetchEntryT      head,
    output logic            empty,
    output logic            full
);

    fetchEntryT mem [queueDepth];

    logic [queuePtrW-1:0] rdPtr;
    logic [queuePtrW-1:0] wrPtr;
    logic [queuePtrW:0]   count;

    // storage only, validity lives in count
    always_ff @(posedge clk) begin
        if (push) begin
            mem[wrPtr] <= pushEntry;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rdPtr <= '0;
            wrPtr <= '0;
            count <= '0;
        end else begin
            // depth is a power of two so the pointers wrap on their own
            if (push) begin
                wrPtr <= wrPtr + 1'b1;
            end
            if (pop) begin
                rdPtr <= rdPtr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    assign head  = mem[rdPtr];
    assign empty = (count == '0);
    assign full  = (count == (queuePtrW + 1)'(queueDepth));

    popWhenEmpty: assert property (
        @(posedge clk) disable iff (rst)
        !(pop && empty)
    ) else $error("pop from empty instruction queue");

    pushWhenFull: assert property (
        @(posedge clk) disable iff (rst)
        !(push && full)
    ) else $error("push into full instruction queue");

endmodule

`default_nettype wire

// File: verilog/rvDecodePkg.sv
/*
 * shared widths, opcode classes, internal opcodes and function codes
 * instruction format views and the decoded record
 */
`default_nettype none

package rvDecodePkg;

    // datapath and register file
    localparam int unsigned xlen = 32;
    localparam int unsigned regNameW = 5;
    localparam logic [regNameW-1:0] nameFree = '0;

    // instruction queue
    localparam int unsigned queueDepth = 4;
    localparam int unsigned queuePtrW = $clog2(queueDepth);

    // branch reservation slots
    localparam int unsigned branchRsSize = 4;
    localparam int unsigned branchTagW = 2;

    // seven bit major opcode field
    typedef enum logic [6:0] {
        classNop    = 7'b0000000,
        classLui    = 7'b0110111,
        classAuipc  = 7'b0010111,
        classJal    = 7'b1101111,
        classJalr   = 7'b1100111,
        classBranch = 7'b1100011,
        classLoad   = 7'b0000011,
        classStore  = 7'b0100011,
        classRegImm = 7'b0010011,
        classRegReg = 7'b0110011
    } opClassT;

    typedef enum logic [5:0] {
        opNop,
        opLui, opAuipc, opJal, opJalr,
        opBeq, opBne, opBlt, opBge, opBltu, opBgeu,
        opLb, opLh, opLw, opLbu, opLhu,
        opSb, opSh, opSw,
        opAdd, opSub, opSll, opSlt, opSltu, opXor, opSrl, opSra, opOr, opAnd
    } opCodeT;

    // funct3 for branches
    localparam logic [2:0] f3Beq  = 3'b000;
    localparam logic [2:0] f3Bne  = 3'b001;
    localparam logic [2:0] f3Blt  = 3'b100;
    localparam logic [2:0] f3Bge  = 3'b101;
    localparam logic [2:0] f3Bltu = 3'b110;
    localparam logic [2:0] f3Bgeu = 3'b111;

    // funct3 for loads and stores
    localparam logic [2:0] f3Lb  = 3'b000;
    localparam logic [2:0] f3Lh  = 3'b001;
    localparam logic [2:0] f3Lw  = 3'b010;
    localparam logic [2:0] f3Lbu = 3'b100;
    localparam logic [2:0] f3Lhu = 3'b101;
    localparam logic [2:0] f3Sb  = 3'b000;
    localparam logic [2:0] f3Sh  = 3'b001;
    localparam logic [2:0] f3Sw  = 3'b010;

    // funct3 for integer ops, shared by register-immediate and register-register
    localparam logic [2:0] f3AddSub = 3'b000;
    localparam logic [2:0] f3Sll    = 3'b001;
    localparam logic [2:0] f3Slt    = 3'b010;
    localparam logic [2:0] f3Sltu   = 3'b011;
    localparam logic [2:0] f3Xor    = 3'b100;
    localparam logic [2:0] f3SrlSra = 3'b101;
    localparam logic [2:0] f3Or     = 3'b110;
    localparam logic [2:0] f3And    = 3'b111;

    localparam logic [6:0] funct7Base = 7'h00;
    localparam logic [6:0] funct7Alt  = 7'h20;

    // instruction formats, msb first
    typedef struct packed {
        logic [6:0]          funct7;
        logic [regNameW-1:0] rs2;
        logic [regNameW-1:0] rs1;
        logic [2:0]          funct3;
        logic [regNameW-1:0] rd;
        logic [6:0]          opcode;
    } rTypeT;

    typedef struct packed {
        logic [11:0]         imm11_0;
        logic [regNameW-1:0] rs1;
        logic [2:0]          funct3;
        logic [regNameW-1:0] rd;
        logic [6:0]          opcode;
    } iTypeT;

    typedef struct packed {
        logic [6:0]          imm11_5;
        logic [regNameW-1:0] rs2;
        logic [regNameW-1:0] rs1;
        logic [2:0]          funct3;
        logic [4:0]          imm4_0;
        logic [6:0]          opcode;
    } sTypeT;

    typedef struct packed {
        logic                imm12;
        logic [5:0]          imm10_5;
        logic [regNameW-1:0] rs2;
        logic [regNameW-1:0] rs1;
        logic [2:0]          funct3;
        logic [3:0]          imm4_1;
        logic                imm11;
        logic [6:0]          opcode;
    } bTypeT;

    typedef struct packed {
        logic [19:0]         imm31_12;
        logic [regNameW-1:0] rd;
        logic [6:0]          opcode;
    } uTypeT;

    typedef struct packed {
        logic                imm20;
        logic [9:0]          imm10_1;
        logic                imm11;
        logic [7:0]          imm19_12;
        logic [regNameW-1:0] rd;
        logic [6:0]          opcode;
    } jTypeT;

    // one word, read in whichever format the decoder needs
    typedef union packed {
        logic [xlen-1:0] raw;
        rTypeT           r;
        iTypeT           i;
        sTypeT           s;
        bTypeT           b;
        uTypeT           u;
        jTypeT           j;
    } instWordT;

    typedef struct packed {
        logic [xlen-1:0] pc;
        instWordT        inst;
    } fetchEntryT;

    typedef struct packed {
        logic [regNameW-1:0]   regNameO;
        logic [regNameW-1:0]   regNameT;
        logic [regNameW-1:0]   rdName;
        opCodeT                opCode;
        opClassT               opClass;
        logic [xlen-1:0]       instAddr;
        logic [xlen-1:0]       imm;
        logic [xlen-1:0]       uImm;
        logic [xlen-1:0]       jImm;
        logic [xlen-1:0]       sImm;
        logic [xlen-1:0]       bImm;
        logic [branchTagW-1:0] branchTag;
    } decodedInstT;

endpackage

`default_nettype wire

// File: verilog/rvFrontEnd.sv
/*
 * instruction front end top with fetch, queue, decoder and branch tags
 */
`timescale 1ns/100ps
`default_nettype none

module rvFrontEnd
    import rvDecodePkg::*;
(
    input  wire logic                  clk,
    input  wire logic                  rst,
    input  wire logic                  fetchValid,
    input  wire logic [xlen-1:0]       fetchInst,
    input  wire logic                  bFreeEn,
    input  wire logic [branchTagW-1:0] bFreeNum,
    output logic                       queueFull,
    output logic                       decValid,
    output decodedInstT                decOut,
    output logic [branchRsSize-1:0]    busyMask,
    output logic                       branchFree
);

    logic                  push;
    fetchEntryT            pushEntry;
    fetchEntryT            head;
    logic                  empty;
    logic                  pop;
    logic                  allocate;
    logic [branchTagW-1:0] allocTag;

    fetchUnit fetch (
        .clk        (clk),
        .rst        (rst),
        .fetchValid (fetchValid),
        .fetchInst  (fetchInst),
        .queueFull  (queueFull),
        .push       (push),
        .pushEntry  (pushEntry)
    );

    instQueue queue (
        .clk       (clk),
        .rst       (rst),
        .push      (push),
        .pushEntry (pushEntry),
        .pop       (pop),
        .head      (head),
        .empty     (empty),
        .full      (queueFull)
    );

    instDecoder decoder (
        .clk        (clk),
        .rst        (rst),
        .head       (head),
        .empty      (empty),
        .branchFree (branchFree),
        .allocTag   (allocTag),
        .pop        (pop),
        .allocate   (allocate),
        .decValid   (decValid),
        .decOut     (decOut)
    );

    branchTagTracker tags (
        .clk        (clk),
        .rst        (rst),
        .allocate   (allocate),
        .bFreeEn    (bFreeEn),
        .bFreeNum   (bFreeNum),
        .allocTag   (allocTag),
        .busyMask   (busyMask),
        .branchFree (branchFree)
    );

endmodule

`default_nettype wire
